/* fetch_cfg.svh */
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define FETCH_ADDR_W      32             // byte address width.
`define FETCH_INSTR_W     32             // one instruction per cache line.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L1 geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define FETCH_NUM_SETS    16             // must be a power of two.
`define FETCH_NUM_WAYS    4              // must be a power of two.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 backing store
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define FETCH_L2_LATENCY  3              // cycles from request pulse to response pulse.
`define FETCH_L2_DEPTH    1024           // words, a power of two.
`define FETCH_L2_PATTERN  32'h5A3C_96E1  // each word is its word address xor this.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// program counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define FETCH_RESET_PC    32'h0000_0000  // first fetch address after reset.

`endif

/* fetch_pkg.sv */
`include "fetch_cfg.svh"

package fetch_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address split
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int OFFSET_W = 2;                                // byte offset inside a word.
    localparam int SET_W    = $clog2(`FETCH_NUM_SETS);
    localparam int WAY_W    = $clog2(`FETCH_NUM_WAYS);
    localparam int TAG_W    = `FETCH_ADDR_W - SET_W - OFFSET_W;

    typedef logic [`FETCH_ADDR_W-1:0]  addr_t;
    typedef logic [`FETCH_INSTR_W-1:0] instr_t;
    typedef logic [SET_W-1:0]          set_idx_t;
    typedef logic [TAG_W-1:0]          tag_t;
    typedef logic [WAY_W-1:0]          way_idx_t;
    typedef logic [WAY_W-1:0]          age_t;               // 0 is the most recent way.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bundles between the blocks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        addr_t  pc;
        instr_t instr;
    } fetch_out_t;

    typedef struct packed {
        logic [`FETCH_ADDR_W-OFFSET_W-1:0] word_addr;           // byte address without offset.
    } l2_req_t;

    typedef struct packed {
        instr_t data;
    } l2_resp_t;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_L2,
        REFILL
    } miss_state_e;

endpackage

/* fetch_pc_gen.sv */
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_pc_gen (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             fetch_en_i,
    input  logic             hit_i,
    input  logic             redirect_i,
    input  fetch_pkg::addr_t redirect_pc_i,
    output fetch_pkg::addr_t pc_o
);

    import fetch_pkg::*;

    localparam addr_t WORD_STEP = addr_t'(4);

    addr_t pc_q;
    logic  advance;

    // the instruction at pc is consumed only when it hits while enabled.
    assign advance = hit_i && fetch_en_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= addr_t'(`FETCH_RESET_PC);
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;            // wins over a hit in the same cycle.
        end else if (advance) begin
            pc_q <= pc_q + WORD_STEP;
        end
    end

    assign pc_o = pc_q;

endmodule

/* icache_lru.sv */
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module icache_lru (
    input  logic                       clk,
    input  logic                       reset_i,
    input  fetch_pkg::set_idx_t        lookup_set_i,
    input  logic [`FETCH_NUM_WAYS-1:0] valid_ways_i,
    output fetch_pkg::way_idx_t        victim_o,
    input  logic                       touch_i,
    input  fetch_pkg::set_idx_t        touch_set_i,
    input  fetch_pkg::way_idx_t        touch_way_i
);

    import fetch_pkg::*;

    localparam int   NUM_SETS = `FETCH_NUM_SETS;
    localparam int   NUM_WAYS = `FETCH_NUM_WAYS;
    localparam age_t MAX_AGE  = age_t'(NUM_WAYS - 1);

    age_t ages_q [NUM_SETS][NUM_WAYS];
    age_t old_age;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // victim selection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        logic found_invalid;
        age_t max_age;
        found_invalid = 1'b0;
        max_age       = '0;
        victim_o      = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!valid_ways_i[w] && !found_invalid) begin
                found_invalid = 1'b1;                    // lowest invalid way wins.
                victim_o      = way_idx_t'(w);
            end else if (!found_invalid && ages_q[lookup_set_i][w] > max_age) begin
                max_age  = ages_q[lookup_set_i][w];      // strict compare keeps the lowest on a tie.
                victim_o = way_idx_t'(w);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // age update
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a fill into an invalid way ages every valid way, as if it came from the oldest slot.
    // the cache looks up the touched set whenever it touches, so valid_ways_i matches.
    assign old_age = valid_ways_i[touch_way_i] ? ages_q[touch_set_i][touch_way_i] : MAX_AGE;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    ages_q[s][w] <= '0;
                end
            end
        end else if (touch_i) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (way_idx_t'(w) == touch_way_i) begin
                    ages_q[touch_set_i][w] <= '0;
                end else if (ages_q[touch_set_i][w] < old_age) begin
                    ages_q[touch_set_i][w] <= ages_q[touch_set_i][w] + 1'b1;
                end
            end
        end
    end

endmodule

/* l1_icache.sv */
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module l1_icache (
    input  logic                clk,
    input  logic                reset_i,
    input  fetch_pkg::addr_t    addr_i,
    input  logic                fetch_en_i,
    output logic                hit_o,
    output fetch_pkg::instr_t   instr_o,
    output logic                l2_req_o,
    output fetch_pkg::l2_req_t  l2_req_data_o,
    input  logic                l2_resp_valid_i,
    input  fetch_pkg::l2_resp_t l2_resp_i
);

    import fetch_pkg::*;

    localparam int NUM_SETS = `FETCH_NUM_SETS;
    localparam int NUM_WAYS = `FETCH_NUM_WAYS;

    tag_t                tag_q   [NUM_SETS][NUM_WAYS];
    instr_t              data_q  [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];

    miss_state_e state_q;
    logic        req_q;
    addr_t       miss_addr_q;

    tag_t                addr_tag;
    set_idx_t            addr_set;
    tag_t                miss_tag;
    set_idx_t            miss_set;
    logic                lookup_hit;
    way_idx_t            hit_way;
    instr_t              hit_data;
    logic                miss_start;
    logic                refill;
    set_idx_t            lru_set;
    logic [NUM_WAYS-1:0] lru_valid;
    way_idx_t            victim;
    logic                touch;
    set_idx_t            touch_set;
    way_idx_t            touch_way;

    assign addr_set = addr_i[SET_W+OFFSET_W-1:OFFSET_W];
    assign addr_tag = addr_i[`FETCH_ADDR_W-1:SET_W+OFFSET_W];
    assign miss_set = miss_addr_q[SET_W+OFFSET_W-1:OFFSET_W];
    assign miss_tag = miss_addr_q[`FETCH_ADDR_W-1:SET_W+OFFSET_W];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // same-cycle lookup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        lookup_hit = 1'b0;
        hit_way    = '0;
        hit_data   = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid_q[addr_set][w] && (tag_q[addr_set][w] == addr_tag)) begin
                lookup_hit = 1'b1;
                hit_way    = way_idx_t'(w);
                hit_data   = data_q[addr_set][w];
            end
        end
    end

    // the REFILL cycle already reads the new line back, only WAIT_L2 blocks delivery.
    assign hit_o   = lookup_hit && (state_q != WAIT_L2);
    assign instr_o = hit_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // miss handling
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign miss_start = (state_q == IDLE) && fetch_en_i && !lookup_hit;
    assign refill     = (state_q == WAIT_L2) && l2_resp_valid_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
            req_q   <= 1'b0;
        end else begin
            req_q <= 1'b0;                               // request is a single-cycle pulse.
            case (state_q)
                IDLE: begin
                    if (miss_start) begin
                        state_q <= WAIT_L2;
                        req_q   <= 1'b1;
                    end
                end
                WAIT_L2: begin
                    if (l2_resp_valid_i) begin
                        state_q <= REFILL;               // a redirect meanwhile does not cancel.
                    end
                end
                REFILL:  state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (miss_start) begin
            miss_addr_q <= addr_i;
        end
    end

    assign l2_req_o                = req_q;
    assign l2_req_data_o.word_addr = miss_addr_q[`FETCH_ADDR_W-1:OFFSET_W];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // refill write and replacement
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (refill) begin
            tag_q[miss_set][victim]  <= miss_tag;
            data_q[miss_set][victim] <= l2_resp_i.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (refill) begin
            valid_q[miss_set][victim] <= 1'b1;
        end
    end

    // while waiting the replacement logic looks at the set being refilled.
    assign lru_set   = (state_q == WAIT_L2) ? miss_set : addr_set;
    assign lru_valid = valid_q[lru_set];
    assign touch     = refill || (hit_o && fetch_en_i);
    assign touch_set = refill ? miss_set : addr_set;
    assign touch_way = refill ? victim : hit_way;

    icache_lru u_lru (
        .clk          (clk),
        .reset_i      (reset_i),
        .lookup_set_i (lru_set),
        .valid_ways_i (lru_valid),
        .victim_o     (victim),
        .touch_i      (touch),
        .touch_set_i  (touch_set),
        .touch_way_i  (touch_way)
    );

endmodule

/* l2_instr_mem.sv */
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module l2_instr_mem (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                req_i,
    input  fetch_pkg::l2_req_t  req_data_i,
    output logic                resp_valid_o,
    output fetch_pkg::l2_resp_t resp_o
);

    import fetch_pkg::*;

    localparam int DEPTH   = `FETCH_L2_DEPTH;
    localparam int LATENCY = `FETCH_L2_LATENCY;
    localparam int IDX_W   = $clog2(DEPTH);

    instr_t             rom [DEPTH];
    instr_t             data_q [LATENCY];
    logic [LATENCY-1:0] valid_q;
    logic [IDX_W-1:0]   rd_idx;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // content rule
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar i = 0; i < DEPTH; i++) begin : g_rom
        assign rom[i] = instr_t'(i) ^ instr_t'(`FETCH_L2_PATTERN);
    end

    assign rd_idx = req_data_i.word_addr[IDX_W-1:0];  // addresses wrap at the store depth.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // latency pipeline
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[LATENCY-2:0], req_i};  // one request may sit in every stage.
        end
    end

    always_ff @(posedge clk) begin
        data_q[0] <= rom[rd_idx];
        for (int s = 1; s < LATENCY; s++) begin
            data_q[s] <= data_q[s-1];
        end
    end

    assign resp_valid_o = valid_q[LATENCY-1];
    assign resp_o.data  = data_q[LATENCY-1];

endmodule

/* instr_fetch_top.sv */
`timescale 1ns/1ps

module instr_fetch_top (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  fetch_en_i,
    input  logic                  redirect_i,
    input  fetch_pkg::addr_t      redirect_pc_i,
    output logic                  fetch_valid_o,
    output fetch_pkg::fetch_out_t fetch_o,
    output logic                  l2_req_o
);

    import fetch_pkg::*;

    addr_t    pc;
    logic     hit;
    instr_t   instr;
    l2_req_t  l2_req_data;
    logic     l2_resp_valid;
    l2_resp_t l2_resp;

    fetch_pc_gen u_pc_gen (
        .clk           (clk),
        .reset_i       (reset_i),
        .fetch_en_i    (fetch_en_i),
        .hit_i         (hit),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .pc_o          (pc)
    );

    l1_icache u_l1 (
        .clk             (clk),
        .reset_i         (reset_i),
        .addr_i          (pc),
        .fetch_en_i      (fetch_en_i),
        .hit_o           (hit),
        .instr_o         (instr),
        .l2_req_o        (l2_req_o),
        .l2_req_data_o   (l2_req_data),
        .l2_resp_valid_i (l2_resp_valid),
        .l2_resp_i       (l2_resp)
    );

    l2_instr_mem u_l2 (
        .clk          (clk),
        .reset_i      (reset_i),
        .req_i        (l2_req_o),
        .req_data_i   (l2_req_data),
        .resp_valid_o (l2_resp_valid),
        .resp_o       (l2_resp)
    );

    assign fetch_valid_o = fetch_en_i && hit;  // same condition that advances the pc.
    assign fetch_o.pc    = pc;
    assign fetch_o.instr = instr;

endmodule

/* instr_fetch_sva.sv */
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module instr_fetch_sva (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  fetch_en_i,
    input  logic                  redirect_i,
    input  logic                  fetch_valid_i,
    input  fetch_pkg::fetch_out_t fetch_i,
    input  logic                  l2_req_i,
    input  logic                  l2_resp_valid_i
);

    import fetch_pkg::*;

    logic   fail_seen = 1'b0;
    instr_t exp_instr;
    addr_t  prev_pc;

    // every L2 word is its word address xor the content pattern.
    assign exp_instr = instr_t'(fetch_i.pc >> OFFSET_W) ^ instr_t'(`FETCH_L2_PATTERN);

    always_ff @(posedge clk) begin
        prev_pc <= fetch_i.pc;                        // pc of the cycle before.
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data and timing rules
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_data: assert property (@(posedge clk) disable iff (reset_i)
        fetch_valid_i |-> fetch_i.instr == exp_instr)
        else begin
            fail_seen = 1'b1;
            $error("CHECK FAILED time=%0t fetch_o.instr expected=%h actual=%h",
                   $time, $sampled(exp_instr), $sampled(fetch_i.instr));
        end

    a_l2_latency: assert property (@(posedge clk) disable iff (reset_i)
        l2_req_i |-> ##(`FETCH_L2_LATENCY) l2_resp_valid_i)
        else begin
            fail_seen = 1'b1;
            $error("CHECK FAILED time=%0t l2_resp_valid expected=1 actual=0", $time);
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (reset_i)
        !fetch_en_i && !redirect_i |=> fetch_i.pc == prev_pc)
        else begin
            fail_seen = 1'b1;
            $error("CHECK FAILED time=%0t fetch_o.pc expected=%h actual=%h",
                   $time, $sampled(prev_pc), $sampled(fetch_i.pc));
        end

endmodule

/* tb_instr_fetch.sv */
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module tb_instr_fetch;

    import fetch_pkg::*;

    localparam int LAT          = `FETCH_L2_LATENCY;
    localparam int NW           = `FETCH_NUM_WAYS;
    localparam int NS           = `FETCH_NUM_SETS;
    localparam int PHASE_CYCLES = 6000;               // rough sum of all phases.

    logic       clk = 1'b0;
    logic       reset_i;
    logic       fetch_en_i;
    logic       redirect_i;
    addr_t      redirect_pc_i;
    logic       fetch_valid_o;
    fetch_out_t fetch_o;
    logic       l2_req_o;

    tag_t        m_tag   [NS][NW];
    logic        m_valid [NS][NW];
    age_t        m_age   [NS][NW];
    miss_state_e m_state;
    int          m_cnt;
    addr_t       m_addr;
    addr_t       exp_pc;
    logic        exp_req;
    int          delivered = 0;
    addr_t       last_pc;
    logic [31:0] rng;
    int          n;

    instr_fetch_top dut (
        .clk           (clk),
        .reset_i       (reset_i),
        .fetch_en_i    (fetch_en_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .fetch_valid_o (fetch_valid_o),
        .fetch_o       (fetch_o),
        .l2_req_o      (l2_req_o)
    );

    bind instr_fetch_top instr_fetch_sva u_sva (
        .clk             (clk),
        .reset_i         (reset_i),
        .fetch_en_i      (fetch_en_i),
        .redirect_i      (redirect_i),
        .fetch_valid_i   (fetch_valid_o),
        .fetch_i         (fetch_o),
        .l2_req_i        (l2_req_o),
        .l2_resp_valid_i (l2_resp_valid)
    );

    always #4 clk = ~clk;

    task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        $display("CHECK FAILED time=%0t %s expected=%h actual=%h", $time, name, exp, got);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic fail_text(input string why);
        $display("ERROR at time=%0t: %s", $time, why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped on error");
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic set_idx_t set_of(input addr_t a);
        return a[SET_W+OFFSET_W-1:OFFSET_W];
    endfunction

    function automatic tag_t tag_of(input addr_t a);
        return a[`FETCH_ADDR_W-1:SET_W+OFFSET_W];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference tags and LRU ages
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic int model_way(input addr_t a);
        for (int w = 0; w < NW; w++) begin
            if (m_valid[set_of(a)][w] && m_tag[set_of(a)][w] == tag_of(a)) return w;
        end
        return -1;                                    // miss.
    endfunction

    function automatic int model_victim(input set_idx_t s);
        int v;
        v = 0;
        for (int w = 0; w < NW; w++) begin
            if (!m_valid[s][w]) return w;             // invalid ways fill first.
        end
        for (int w = 1; w < NW; w++) begin
            if (m_age[s][w] > m_age[s][v]) v = w;
        end
        return v;
    endfunction

    task automatic model_touch(input set_idx_t s, input int way);
        age_t old;
        old = m_valid[s][way] ? m_age[s][way] : age_t'(NW - 1);
        for (int w = 0; w < NW; w++) begin
            if (w == way) m_age[s][w] = '0;
            else if (m_age[s][w] < old) m_age[s][w] = m_age[s][w] + 1'b1;
        end
    endtask

    always @(posedge clk) begin
        int   way;
        int   vic;
        logic hit_exp;
        if (reset_i) begin
            foreach (m_valid[s, w]) begin
                m_valid[s][w] = 1'b0;
                m_age[s][w]   = '0;
            end
            m_state = IDLE;
            exp_pc  = addr_t'(`FETCH_RESET_PC);
            exp_req = 1'b0;
        end else begin
            way     = model_way(exp_pc);
            hit_exp = (way >= 0) && (m_state != WAIT_L2);
            assert (fetch_o.pc == exp_pc) else fail_value("fetch_o.pc", exp_pc, fetch_o.pc);
            assert (fetch_valid_o == (fetch_en_i && hit_exp))
                else fail_value("fetch_valid_o", fetch_en_i && hit_exp, fetch_valid_o);
            assert (l2_req_o == exp_req) else fail_value("l2_req_o", exp_req, l2_req_o);
            exp_req = 1'b0;
            if (fetch_valid_o) begin
                delivered++;
                last_pc = fetch_o.pc;
            end
            case (m_state)
                IDLE: begin
                    if (fetch_en_i && way < 0) begin
                        m_state = WAIT_L2;
                        m_cnt   = 1;
                        m_addr  = exp_pc;
                        exp_req = 1'b1;               // pulse in the next cycle.
                    end else if (fetch_en_i && hit_exp) begin
                        model_touch(set_of(exp_pc), way);
                    end
                end
                WAIT_L2: begin
                    if (m_cnt == LAT + 1) begin       // response cycle ends here.
                        vic = model_victim(set_of(m_addr));
                        model_touch(set_of(m_addr), vic);
                        m_valid[set_of(m_addr)][vic] = 1'b1;
                        m_tag[set_of(m_addr)][vic]   = tag_of(m_addr);
                        m_state = REFILL;
                    end else begin
                        m_cnt++;
                    end
                end
                default: begin
                    if (fetch_en_i && hit_exp) model_touch(set_of(exp_pc), way);
                    m_state = IDLE;
                end
            endcase
            if (redirect_i) exp_pc = redirect_pc_i;
            else if (fetch_en_i && hit_exp) exp_pc = exp_pc + 32'd4;
        end
    end

    always @(posedge clk) begin
        if (dut.u_sva.fail_seen) fail_text("a bound assertion in instr_fetch_sva fired");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic wait_delivered(input int count);
        int target;
        target = delivered + count;
        while (delivered < target) @(negedge clk);
    endtask

    task automatic redirect_to(input addr_t a, input logic en);
        @(negedge clk);
        redirect_i    = 1'b1;
        redirect_pc_i = a;
        fetch_en_i    = en;
        @(negedge clk);
        redirect_i    = 1'b0;
    endtask

    task automatic fetch_one(input addr_t a);
        redirect_to(a, 1'b0);
        fetch_en_i = 1'b1;
        wait_delivered(1);
        fetch_en_i = 1'b0;
    endtask

    initial begin
        #(PHASE_CYCLES * (LAT + 2) * 8 + 10000);
        fail_text("watchdog timeout, the run did not finish");
    end

    initial begin
        reset_i       = 1'b1;
        fetch_en_i    = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        rng           = 32'h45dcb711;
        repeat (3) @(negedge clk);
        reset_i = 1'b0;

        // cold miss, then an 8-word loop fetched twice.
        @(negedge clk);
        fetch_en_i = 1'b1;
        n = 0;
        @(posedge clk);
        while (!fetch_valid_o) begin
            n++;
            @(posedge clk);
        end
        assert (n == LAT + 2) else fail_value("cold miss latency", LAT + 2, n);
        @(negedge clk);
        wait_delivered(7);
        redirect_to(32'h0, 1'b1);
        wait_delivered(8);

        // one address more than a set holds, all in set 14.
        for (int k = 0; k < NW; k++) fetch_one(32'h138 + k * 32'h40);
        fetch_one(32'h138);
        fetch_one(32'h138 + NW * 32'h40);
        for (int k = 0; k < NW; k++) fetch_one(32'h138 + k * 32'h40);

        // stall, then a redirect while the miss waits on L2.
        redirect_to(32'h0, 1'b1);
        wait_delivered(3);
        fetch_en_i = 1'b0;
        repeat (5) @(negedge clk);
        redirect_to(32'h300, 1'b1);
        repeat (2) @(negedge clk);
        redirect_to(32'h200, 1'b1);
        wait_delivered(1);
        assert (last_pc == 32'h200) else fail_value("first pc after redirect", 32'h200, last_pc);

        // random redirects into a 64-word region.
        for (int i = 0; i < 300; i++) begin
            rng = lcg_next(rng);
            redirect_to(32'h400 + {rng[21:16], 2'b00}, rng[24]);
            repeat (rng[3:0]) begin
                rng = lcg_next(rng);
                @(negedge clk);
                fetch_en_i = rng[28];
            end
        end
        fetch_en_i = 1'b0;
        repeat (LAT + 4) @(negedge clk);

        if (dut.u_sva.fail_seen) begin
            fail_text("a bound assertion in instr_fetch_sva fired");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

/* project.f */
+incdir+.
fetch_pkg.sv
fetch_pc_gen.sv
icache_lru.sv
l1_icache.sv
l2_instr_mem.sv
instr_fetch_top.sv
instr_fetch_sva.sv
tb_instr_fetch.sv
